//--- fdc_regs_pkg.sv
package fdc_regs_pkg;

	// --------------------------------------------------
	// host register map
	// --------------------------------------------------
	typedef enum logic [2:0] {
		addr_cmd    = 3'b000, // command on write, status on read
		addr_track  = 3'b001,
		addr_sector = 3'b010,
		addr_data   = 3'b011,
		addr_ctl2   = 3'b111  // secondary control, drive and side
	} reg_addr_e;

	// command upper nibble
	typedef enum logic [3:0] {
		cmd_restore      = 4'h0,
		cmd_seek         = 4'h1,
		cmd_step         = 4'h2,
		cmd_step_upd     = 4'h3,
		cmd_step_in      = 4'h4,
		cmd_step_in_upd  = 4'h5,
		cmd_step_out     = 4'h6,
		cmd_step_out_upd = 4'h7,
		cmd_read_sect    = 4'h8,
		cmd_read_multi   = 4'h9,
		cmd_write_sect   = 4'ha,
		cmd_write_multi  = 4'hb,
		cmd_read_addr    = 4'hc,
		cmd_force_int    = 4'hd,
		cmd_read_track   = 4'he,
		cmd_write_track  = 4'hf
	} fdc_cmd_e;

	// --------------------------------------------------
	// status bits, type I name first, type II second
	// --------------------------------------------------
	localparam int sbit_busy             = 0;
	localparam int sbit_drq_index        = 1;
	localparam int sbit_lost_track0      = 2;
	localparam int sbit_crcerr           = 3;
	localparam int sbit_seekerr          = 4; // record not found on type II
	localparam int sbit_headload_wrfault = 5;
	localparam int sbit_readonly         = 6;
	localparam int sbit_notready         = 7;

	// disk geometry
	localparam int sector_size       = 1024;
	localparam int sectors_per_track = 5;
	localparam int readaddr_len      = 6;  // track, side, sector, size code, crc hi/lo
	localparam int buff_aw           = 10; // covers one sector

endpackage

//--- fdc_host_pkg.sv
package fdc_host_pkg;

	// request upper nibble towards the workhorse cpu
	typedef enum logic [3:0] {
		req_read     = 4'h1, // fill buffer from image
		req_write    = 4'h2, // flush buffer to image
		req_readaddr = 4'h3, // id field into buffer
		req_nop      = 4'h4, // head command, low nibble is the opcode
		req_ack      = 4'h8, // idle
		req_fail     = 4'hc
	} wh_req_e;

	// workhorse status nibble
	localparam int whs_done    = 0;
	localparam int whs_ok      = 1;
	localparam int whs_crc     = 2;
	localparam int whs_noimage = 3; // no disk image mounted

	// timing
	localparam int drq_timeout = 255; // cycles a byte may sit in drq
	localparam int fetch_delay = 15;  // buffer read to drq

endpackage

//--- fdc_drq_watchdog.sv
`timescale 1ns/10ps

module fdc_drq_watchdog (
	input  logic clk,
	input  logic cock,
	input  logic kick,
	output logic expired
);
	import fdc_host_pkg::*;

	logic [15:0] count;

	// retriggerable, parks at zero
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			count <= '0;
		end else if (kick) begin
			count <= 16'(drq_timeout); // fresh byte on offer
		end else if (count != '0) begin
			count <= count - 16'd1;
		end
	end

	// host missed the byte
	assign expired = (count == '0);

endmodule

//--- fdc_sector_buffer.sv
`timescale 1ns/10ps

module fdc_sector_buffer (
	input  logic                            clk,
	// controller side
	input  logic [fdc_regs_pkg::buff_aw-1:0] a_addr,
	input  logic [7:0]                      a_wdata,
	input  logic                            a_we,
	output logic [7:0]                      a_rdata,
	// workhorse side
	input  logic [fdc_regs_pkg::buff_aw-1:0] b_addr,
	input  logic [7:0]                      b_wdata,
	input  logic                            b_we,
	output logic [7:0]                      b_rdata
);
	import fdc_regs_pkg::*;

	logic [7:0] mem [0:sector_size-1]; // one sector

	// both ports synchronous, one cycle read latency
	always_ff @(posedge clk) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
		end
		if (b_we) begin
			mem[b_addr] <= b_wdata; // workhorse wins a same-address clash
		end
		a_rdata <= mem[a_addr];
		b_rdata <= mem[b_addr];
	end

endmodule

//--- fdc_host_regs.sv
`timescale 1ns/10ps

module fdc_host_regs (
	input  logic                    clk,
	input  logic                    cock,
	input  logic                    rd,
	input  logic                    wr,
	input  fdc_regs_pkg::reg_addr_e addr,
	input  logic [7:0]              idata,
	input  logic                    busy,
	input  logic [7:0]              status,
	input  logic                    track_load,
	input  logic [7:0]              track_val,
	input  logic                    sector_inc,
	input  logic                    data_load,
	input  logic [7:0]              load_val,
	output logic [7:0]              odata,
	output logic [7:0]              track,
	output logic [7:0]              sector,
	output logic [7:0]              datareg,
	output logic                    side,
	output logic                    drive,
	output logic                    cmd_strobe,
	output logic [7:0]              cmd,
	output logic                    data_read,
	output logic                    data_write
);
	import fdc_regs_pkg::*;

	// strobes to the fsm, same cycle as the host access
	assign cmd_strobe = wr && (addr == addr_cmd);
	assign cmd        = idata;
	assign data_write = wr && (addr == addr_data);
	assign data_read  = rd && (addr == addr_data);

	// --------------------------------------------------
	// track, sector, ctl2
	// --------------------------------------------------
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			track  <= 8'h00;
			sector <= 8'h00;
			side   <= 1'b0;
			drive  <= 1'b0;
		end else begin
			if (track_load) begin
				track <= track_val; // restore or step with update
			end else if (wr && (addr == addr_track) && !busy) begin
				track <= idata;
			end
			if (sector_inc) begin
				sector <= sector + 8'd1; // multi-sector advance
			end else if (wr && (addr == addr_sector) && !busy) begin
				sector <= idata;
			end
			if (wr && (addr == addr_ctl2)) begin
				side  <= idata[2];
				drive <= idata[0];
			end
		end
	end

	// data register, buffer byte or host byte
	always_ff @(posedge clk) begin
		if (data_load) begin
			datareg <= load_val;
		end else if (data_write) begin
			datareg <= idata;
		end
	end

	// registered read mux, valid the cycle after rd
	always_ff @(posedge clk) begin
		if (rd) begin
			case (addr)
				addr_cmd:    odata <= status;
				addr_track:  odata <= track;
				addr_sector: odata <= sector;
				addr_data:   odata <= datareg;
				addr_ctl2:   odata <= {5'b11111, side, 1'b1, drive}; // spare bits float high
				default:     odata <= 8'hff;
			endcase
		end
	end

endmodule

//--- fdc_ctrl_fsm.sv
`timescale 1ns/10ps

module fdc_ctrl_fsm (
	input  logic                            clk,
	input  logic                            cock,
	input  logic                            cmd_strobe,
	input  logic [7:0]                      cmd,
	input  logic                            data_read,
	input  logic                            data_write,
	input  logic [7:0]                      track,
	input  logic [7:0]                      sector,
	input  logic [7:0]                      datareg,
	input  logic                            side,
	input  logic                            drive,
	input  logic [7:0]                      wh_status,
	input  logic [7:0]                      buff_rdata,
	input  logic                            expired,
	output logic [7:0]                      status,
	output logic                            busy,
	output logic                            drq,
	output logic                            irq,
	output logic                            track_load,
	output logic [7:0]                      track_val,
	output logic                            sector_inc,
	output logic                            data_load,
	output logic [7:0]                      wh_request,
	output logic [fdc_regs_pkg::buff_aw-1:0] buff_addr,
	output logic                            buff_we,
	output logic                            kick
);
	import fdc_regs_pkg::*;
	import fdc_host_pkg::*;

	typedef enum logic [3:0] {
		st_ready, st_wait_ack, st_wait_rd, st_fetch, st_fetch_wait, st_next_addr,
		st_write_sect, st_write_1, st_write_2, st_wait_wr, st_reset
	} state_e;

	state_e    state;
	fdc_cmd_e  opcode;
	wh_req_e   req_code;
	logic [3:0] req_nib;      // drive/side or head opcode
	logic [7:0] head;         // real head position
	logic       step_dir;     // 1 = out, towards track 0
	logic       multi;
	logic       cmd_mode;     // 0 type I status, 1 type II
	logic       rdaddr;       // read address in progress
	logic       s_headload, s_index, s_seekerr, s_crcerr;
	logic       s_lost, s_wrfault, s_notready;
	logic [10:0] byte_cnt;    // bytes left in this sector
	logic [3:0]  fetch_tmr;

	logic        new_dir;
	logic [7:0]  next_head;
	logic [10:0] cnt_m1;
	logic        force_int, type1, type2;
	logic        wh_good, wh_fail, more_sect;

	assign opcode     = fdc_cmd_e'(cmd[7:4]);
	assign wh_request = {req_code, req_nib};

	// --------------------------------------------------
	// decode helpers
	// --------------------------------------------------
	assign new_dir   = cmd[6] ? cmd[5] : step_dir; // plain step keeps last direction
	assign next_head = new_dir ? head - 8'd1 : head + 8'd1;
	assign cnt_m1    = byte_cnt - 11'd1;
	assign force_int = cmd_strobe && (opcode == cmd_force_int);
	assign type1     = !cmd[7];
	assign type2     = cmd[7] && (cmd[6:4] <= 3'd4); // 8..c
	assign wh_good   = wh_status[whs_done] && wh_status[whs_ok];
	assign wh_fail   = wh_status[whs_noimage] || (wh_status[whs_done] && !wh_status[whs_ok]);
	assign more_sect = multi && (sector <= 8'(sectors_per_track));

	// byte goes into the data register as drq rises
	assign data_load = (state == st_fetch_wait) && (fetch_tmr == 4'd0);

	always_comb begin
		status                 = '0;
		status[sbit_busy]      = busy;
		status[sbit_crcerr]    = s_crcerr;
		status[sbit_seekerr]   = s_seekerr;
		status[sbit_readonly]  = 1'b0; // images never write protected
		status[sbit_notready]  = s_notready;
		if (cmd_mode) begin
			status[sbit_drq_index]        = drq;
			status[sbit_lost_track0]      = s_lost;
			status[sbit_headload_wrfault] = s_wrfault;
		end else begin
			status[sbit_drq_index]        = s_index;
			status[sbit_lost_track0]      = (head == 8'h00);
			status[sbit_headload_wrfault] = s_headload;
		end
	end

	// --------------------------------------------------
	// main sequencer
	// --------------------------------------------------
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state      <= st_ready;
			req_code   <= req_ack;
			req_nib    <= 4'h0;
			head       <= 8'hff; // unknown until restore
			step_dir   <= 1'b0;
			multi      <= 1'b0;
			cmd_mode   <= 1'b0;
			rdaddr     <= 1'b0;
			{s_headload, s_index, s_seekerr, s_crcerr} <= '0;
			{s_lost, s_wrfault, s_notready} <= '0;
			{busy, drq, irq} <= '0;
			byte_cnt   <= '0;
			fetch_tmr  <= '0;
			buff_addr  <= '0;
			track_load <= 1'b0;
			track_val  <= 8'h00;
			sector_inc <= 1'b0;
			buff_we    <= 1'b0;
			kick       <= 1'b0;
		end else begin
			track_load <= 1'b0;
			sector_inc <= 1'b0;
			buff_we    <= 1'b0;
			kick       <= 1'b0;
			s_notready <= wh_status[whs_noimage];

			if (force_int) begin
				state <= st_reset; // abort whatever runs
			end else begin
				case (state)
				st_ready: begin
					if (cmd_strobe && !busy) begin
						if (type1) begin
							cmd_mode   <= 1'b0;
							s_headload <= cmd[3];
							s_index    <= 1'b1;
							busy       <= 1'b1;
							irq        <= 1'b0;
							req_code   <= req_nop;
							req_nib    <= cmd[7:4];
							state      <= st_wait_ack;
						end
						if (type2) begin
							cmd_mode <= 1'b1;
							busy     <= 1'b1;
							irq      <= 1'b0;
							{s_seekerr, s_crcerr, s_lost, s_wrfault} <= '0;
							multi    <= cmd[4];
							rdaddr   <= 1'b0;
							req_nib  <= {2'b00, drive, side};
							byte_cnt <= (opcode == cmd_read_addr) ? 11'(readaddr_len)
								: 11'(sector_size);
						end
						case (opcode)
						cmd_restore: begin
							head       <= 8'h00;
							track_load <= 1'b1;
							track_val  <= 8'h00;
						end
						cmd_seek: begin
							head     <= datareg; // target comes in the data register
							step_dir <= (datareg < track);
						end
						cmd_step, cmd_step_upd, cmd_step_in, cmd_step_in_upd,
						cmd_step_out, cmd_step_out_upd: begin
							step_dir   <= new_dir;
							head       <= next_head;
							track_load <= cmd[4]; // update flag
							track_val  <= next_head;
						end
						cmd_read_sect, cmd_read_multi: begin
							req_code <= req_read;
							state    <= st_wait_rd;
						end
						cmd_read_addr: begin
							req_code <= req_readaddr;
							rdaddr   <= 1'b1;
							state    <= st_wait_rd;
						end
						cmd_write_sect, cmd_write_multi: begin
							drq       <= 1'b1; // first byte wanted at once
							buff_addr <= '0;
							state     <= st_write_sect;
						end
						cmd_force_int, cmd_read_track, cmd_write_track: ; // track ops ignored
						endcase
					end else if (drq && (data_read || expired)) begin
						drq  <= 1'b0;
						kick <= 1'b1;
						if (!data_read) begin
							s_lost <= 1'b1; // byte skipped
						end
						if (cnt_m1 != '0) begin
							state <= st_next_addr;
						end else if (more_sect) begin
							sector_inc <= 1'b1;
							req_code   <= req_read;
							req_nib    <= {2'b00, drive, side};
							byte_cnt   <= 11'(sector_size);
							state      <= st_wait_rd;
						end else begin
							busy  <= 1'b0;
							irq   <= 1'b1;
							multi <= 1'b0;
						end
					end
				end
				st_wait_ack: begin
					if (wh_status[whs_done]) begin // any done ends a head command
						req_code <= req_ack;
						busy     <= 1'b0;
						irq      <= 1'b1;
						state    <= st_ready;
					end
				end
				st_wait_rd: begin
					if (wh_fail) begin
						req_code  <= req_ack;
						s_seekerr <= 1'b1;
						s_crcerr  <= wh_status[whs_crc];
						busy      <= 1'b0;
						irq       <= 1'b1;
						multi     <= 1'b0;
						state     <= st_ready;
					end else if (wh_good) begin
						req_code  <= req_ack;
						buff_addr <= '0;
						kick      <= 1'b1;
						state     <= st_fetch;
					end
				end
				st_fetch: begin
					fetch_tmr <= 4'(fetch_delay);
					state     <= st_fetch_wait;
				end
				st_fetch_wait: begin
					if (fetch_tmr != 4'd0) begin
						fetch_tmr <= fetch_tmr - 4'd1;
					end else begin
						drq <= 1'b1;
						if (rdaddr && (buff_addr == '0)) begin
							head <= buff_rdata; // id field tells where the head really is
						end
						state <= st_ready;
					end
				end
				st_next_addr: begin
					buff_addr <= buff_addr + 1'b1;
					byte_cnt  <= cnt_m1;
					fetch_tmr <= 4'(fetch_delay);
					state     <= st_fetch_wait;
				end
				st_write_sect: begin
					if (data_write) begin
						drq   <= 1'b0;
						state <= st_write_1;
					end
				end
				st_write_1: begin
					buff_we <= 1'b1; // data register into buffer
					state   <= st_write_2;
				end
				st_write_2: begin
					buff_addr <= buff_addr + 1'b1;
					byte_cnt  <= cnt_m1;
					if (cnt_m1 == '0) begin
						req_code <= req_write; // sector complete, flush
						req_nib  <= {2'b00, drive, side};
						state    <= st_wait_wr;
					end else begin
						drq   <= 1'b1;
						state <= st_write_sect;
					end
				end
				st_wait_wr: begin
					if (wh_fail) begin
						req_code  <= req_ack;
						s_wrfault <= 1'b1;
						s_seekerr <= 1'b1;
						s_crcerr  <= wh_status[whs_crc];
						busy      <= 1'b0;
						irq       <= 1'b1;
						multi     <= 1'b0;
						state     <= st_ready;
					end else if (wh_good) begin
						req_code <= req_ack;
						if (more_sect) begin
							sector_inc <= 1'b1;
							drq        <= 1'b1;
							byte_cnt   <= 11'(sector_size);
							buff_addr  <= '0;
							state      <= st_write_sect;
						end else begin
							busy  <= 1'b0;
							irq   <= 1'b1;
							state <= st_ready;
						end
					end
				end
				st_reset: begin
					drq      <= 1'b0;
					busy     <= 1'b0;
					multi    <= 1'b0;
					req_code <= req_ack;
					{s_seekerr, s_crcerr, s_lost, s_wrfault} <= '0;
					state    <= st_ready; // irq untouched
				end
				default: state <= st_ready;
				endcase
			end
		end
	end

endmodule

//--- fdc_top.sv
`timescale 1ns/10ps

module fdc_top (
	input  logic                            clk,
	input  logic                            cock,
	// host cpu
	input  logic                            rd,
	input  logic                            wr,
	input  fdc_regs_pkg::reg_addr_e         addr,
	input  logic [7:0]                      idata,
	output logic [7:0]                      odata,
	output logic                            irq,
	output logic                            drq,
	// workhorse cpu
	output logic [7:0]                      wh_request,
	input  logic [7:0]                      wh_status,
	input  logic [fdc_regs_pkg::buff_aw-1:0] wh_addr,
	input  logic [7:0]                      wh_wdata,
	input  logic                            wh_we,
	output logic [7:0]                      wh_rdata
);
	import fdc_regs_pkg::*;

	// --------------------------------------------------
	// registers <-> fsm
	// --------------------------------------------------
	logic [7:0] track, sector, datareg;
	logic       side, drive;
	logic       cmd_strobe;
	logic [7:0] cmd;
	logic       data_read, data_write;
	logic       busy;
	logic [7:0] status;
	logic       track_load, sector_inc, data_load;
	logic [7:0] track_val;

	// buffer port a and timer
	logic [buff_aw-1:0] buff_addr;
	logic [7:0]         buff_rdata;
	logic               buff_we;
	logic               kick, expired;

	fdc_host_regs regs_inst (
		.clk        (clk),
		.cock       (cock),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.idata      (idata),
		.busy       (busy),
		.status     (status),
		.track_load (track_load),
		.track_val  (track_val),
		.sector_inc (sector_inc),
		.data_load  (data_load),
		.load_val   (buff_rdata), // fetched byte
		.odata      (odata),
		.track      (track),
		.sector     (sector),
		.datareg    (datareg),
		.side       (side),
		.drive      (drive),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.data_read  (data_read),
		.data_write (data_write)
	);

	fdc_ctrl_fsm fsm_inst (
		.clk        (clk),
		.cock       (cock),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.data_read  (data_read),
		.data_write (data_write),
		.track      (track),
		.sector     (sector),
		.datareg    (datareg),
		.side       (side),
		.drive      (drive),
		.wh_status  (wh_status),
		.buff_rdata (buff_rdata),
		.expired    (expired),
		.status     (status),
		.busy       (busy),
		.drq        (drq),
		.irq        (irq),
		.track_load (track_load),
		.track_val  (track_val),
		.sector_inc (sector_inc),
		.data_load  (data_load),
		.wh_request (wh_request),
		.buff_addr  (buff_addr),
		.buff_we    (buff_we),
		.kick       (kick)
	);

	fdc_drq_watchdog dog_inst (
		.clk     (clk),
		.cock    (cock),
		.kick    (kick),
		.expired (expired)
	);

	// port a controller, port b workhorse
	fdc_sector_buffer buff_inst (
		.clk     (clk),
		.a_addr  (buff_addr),
		.a_wdata (datareg), // host byte on write sector
		.a_we    (buff_we),
		.a_rdata (buff_rdata),
		.b_addr  (wh_addr),
		.b_wdata (wh_wdata),
		.b_we    (wh_we),
		.b_rdata (wh_rdata)
	);

endmodule

//--- fdc_tb.sv
`timescale 1ns/10ps

module fdc_tb;
	import fdc_regs_pkg::*;
	import fdc_host_pkg::*;

	localparam int wait_limit = 2000; // cycles, a full buffer copy fits easily

	logic               clk;
	logic               cock;
	logic               rd;
	logic               wr;
	reg_addr_e          addr;
	logic [7:0]         idata;
	logic [7:0]         odata;
	logic               irq;
	logic               drq;
	logic [7:0]         wh_request;
	logic [7:0]         wh_status;
	logic [buff_aw-1:0] wh_addr;
	logic [7:0]         wh_wdata;
	logic               wh_we;
	logic [7:0]         wh_rdata;

	integer     seed;
	int         errors;
	int         checks;
	int         read_reqs;                    // read requests served so far
	logic [7:0] last_req;                     // last request seen by the model
	logic [7:0] fail_answer;                  // nonzero: next read/write gets this
	logic [7:0] fill_copy  [0:sector_size-1]; // bytes the model put in the buffer
	logic [7:0] flush_copy [0:sector_size-1]; // bytes the model took out
	logic [7:0] sent       [0:sector_size-1]; // bytes the host wrote

	fdc_top fdc_top_inst (
		.clk        (clk),
		.cock       (cock),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.idata      (idata),
		.odata      (odata),
		.irq        (irq),
		.drq        (drq),
		.wh_request (wh_request),
		.wh_status  (wh_status),
		.wh_addr    (wh_addr),
		.wh_wdata   (wh_wdata),
		.wh_we      (wh_we),
		.wh_rdata   (wh_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	function automatic logic [7:0] bit_mask(input int pos);
		bit_mask = 8'h01 << pos;
	endfunction

	// --------------------------------------------------
	// workhorse model
	// --------------------------------------------------
	task automatic fill_buffer();
		int i;
		for (i = 0; i < sector_size; i++) begin
			wh_addr      = buff_aw'(i);
			wh_wdata     = 8'($random(seed));
			wh_we        = 1'b1;
			fill_copy[i] = wh_wdata; // keep for the host side compare
			@(negedge clk);
		end
		wh_we = 1'b0;
	endtask

	task automatic drain_buffer();
		int i;
		for (i = 0; i < sector_size; i++) begin
			wh_addr = buff_aw'(i);
			@(negedge clk);
			flush_copy[i] = wh_rdata; // one cycle read latency
		end
	endtask

	// hold the answer until the request drops back to ack
	task automatic answer_request(input logic [7:0] ans);
		int n;
		wh_status = ans;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (wh_request[7:4] == req_ack) begin
				break;
			end
		end
		if (wh_request[7:4] != req_ack) begin
			$display("workhorse model: request %h was never released", wh_request);
			errors++;
		end
		wh_status = 8'h00;
	endtask

	initial begin
		wh_status = 8'h00;
		wh_addr   = '0;
		wh_wdata  = 8'h00;
		wh_we     = 1'b0;
		forever begin
			@(negedge clk);
			if (!cock && (wh_request[7:4] != req_ack)) begin
				last_req = wh_request;
				repeat (2) @(negedge clk); // think time
				case (wh_req_e'(wh_request[7:4]))
				req_read, req_readaddr: begin
					read_reqs++;
					if (fail_answer != 8'h00) begin
						answer_request(fail_answer); // programmed failure, no fill
						fail_answer = 8'h00;
					end else begin
						fill_buffer();
						answer_request(bit_mask(whs_done) | bit_mask(whs_ok));
					end
				end
				req_write: begin
					drain_buffer();
					answer_request(bit_mask(whs_done) | bit_mask(whs_ok));
				end
				default: answer_request(bit_mask(whs_done)); // head command
				endcase
			end
		end
	end

	// --------------------------------------------------
	// host bus, waits and compares
	// --------------------------------------------------
	task automatic host_write(input reg_addr_e a, input logic [7:0] d);
		addr  = a;
		idata = d;
		wr    = 1'b1;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic host_read(input reg_addr_e a, output logic [7:0] d);
		addr = a;
		rd   = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		d  = odata; // registered at the edge that saw rd
	endtask

	task automatic wait_drq(input string what, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			if (drq) begin
				ok = 1'b1;
				break;
			end
			@(negedge clk);
		end
		if (!ok) begin
			$display("timeout waiting for drq in %s", what);
			errors++;
		end
	endtask

	task automatic wait_irq(input string what, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			if (irq) begin
				ok = 1'b1;
				break;
			end
			@(negedge clk);
		end
		if (!ok) begin
			$display("timeout waiting for irq in %s", what);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_req(input string name, input wh_req_e expected, input wh_req_e actual);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch %s: expected %s (%h), actual %s (%h)", name,
				expected.name(), expected, actual.name(), actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_registers();
		int         e0;
		logic [7:0] v;
		e0 = errors;
		host_read(addr_cmd, v);
		check_byte("reset track0", 8'h00, v & bit_mask(sbit_lost_track0)); // head at 0xff
		check_byte("reset irq", 8'h00, {7'b0, irq});
		host_write(addr_track, 8'h5a);
		host_write(addr_sector, 8'h03);
		host_write(addr_ctl2, 8'h01);
		host_read(addr_track, v);
		check_byte("track readback", 8'h5a, v);
		host_read(addr_sector, v);
		check_byte("sector readback", 8'h03, v);
		host_read(addr_ctl2, v);
		check_byte("ctl2 readback", 8'hfb, v); // only the side bit reads low
		report_test("registers", e0);
	endtask

	task automatic test_head();
		int         e0;
		bit         ok;
		logic [7:0] v;
		logic [7:0] t0;
		e0 = errors;
		t0 = bit_mask(sbit_lost_track0) | bit_mask(sbit_busy);
		host_write(addr_cmd, {cmd_restore, 4'h0});
		wait_irq("restore", ok);
		check_req("restore request", req_nop, wh_req_e'(last_req[7:4]));
		check_byte("restore nibble", 8'h00, {4'h0, last_req[3:0]});
		host_read(addr_track, v);
		check_byte("restore track", 8'h00, v);
		host_read(addr_cmd, v);
		check_byte("restore status", bit_mask(sbit_lost_track0), v & t0);
		// step in with update, one track inwards
		host_write(addr_cmd, {cmd_step_in_upd, 4'h0});
		wait_irq("step in", ok);
		check_byte("step in nibble", {4'h0, cmd_step_in_upd}, {4'h0, last_req[3:0]});
		host_read(addr_track, v);
		check_byte("step in track", 8'h01, v);
		host_read(addr_cmd, v);
		check_byte("step in status", 8'h00, v & t0);
		// step out, register untouched but head back on 0
		host_write(addr_cmd, {cmd_step_out, 4'h0});
		wait_irq("step out", ok);
		host_read(addr_track, v);
		check_byte("step out track", 8'h01, v);
		host_read(addr_cmd, v);
		check_byte("step out status", bit_mask(sbit_lost_track0), v & t0);
		report_test("head commands", e0);
	endtask

	task automatic test_read_single();
		int         e0;
		int         i;
		bit         ok;
		logic [7:0] v;
		e0 = errors;
		host_write(addr_cmd, {cmd_read_sect, 4'h0});
		for (i = 0; i < sector_size; i++) begin
			wait_drq("single read", ok);
			if (!ok) begin
				break;
			end
			host_read(addr_data, v);
			check_byte($sformatf("read byte %0d", i), fill_copy[i], v);
		end
		wait_irq("single read", ok);
		check_req("read request", req_read, wh_req_e'(last_req[7:4]));
		host_read(addr_cmd, v);
		check_byte("read status", 8'h00,
			v & (bit_mask(sbit_busy) | bit_mask(sbit_lost_track0))); // no lost data
		report_test("single sector read", e0);
	endtask

	task automatic test_write();
		int         e0;
		int         i;
		bit         ok;
		logic [7:0] v;
		e0 = errors;
		host_write(addr_ctl2, 8'h04); // side 1, drive 0
		host_write(addr_cmd, {cmd_write_sect, 4'h0});
		for (i = 0; i < sector_size; i++) begin
			wait_drq("write sector", ok);
			if (!ok) begin
				break;
			end
			sent[i] = 8'($random(seed));
			host_write(addr_data, sent[i]);
		end
		wait_irq("write sector", ok);
		check_req("write request", req_write, wh_req_e'(last_req[7:4]));
		check_byte("write nibble", 8'h01, {4'h0, last_req[3:0]}); // side bit
		for (i = 0; i < sector_size; i++) begin
			check_byte($sformatf("written byte %0d", i), sent[i], flush_copy[i]);
		end
		host_read(addr_cmd, v);
		check_byte("write status", 8'h00,
			v & (bit_mask(sbit_busy) | bit_mask(sbit_headload_wrfault)));
		report_test("write sector", e0);
	endtask

	task automatic test_failure();
		int         e0;
		bit         ok;
		logic [7:0] v;
		logic [7:0] errs;
		e0   = errors;
		errs = bit_mask(sbit_seekerr) | bit_mask(sbit_crcerr);
		fail_answer = bit_mask(whs_done) | bit_mask(whs_crc); // done, not ok
		host_write(addr_cmd, {cmd_read_sect, 4'h0});
		wait_irq("failed read", ok);
		host_read(addr_cmd, v);
		check_byte("failure status", errs, v & (errs | bit_mask(sbit_busy)));
		report_test("workhorse failure", e0);
	endtask

	task automatic test_multi_lost();
		int         e0;
		int         i;
		int         r0;
		bit         ok;
		logic [7:0] v;
		logic [7:0] bl;
		e0 = errors;
		bl = bit_mask(sbit_busy) | bit_mask(sbit_lost_track0);
		host_write(addr_sector, 8'h04);
		r0 = read_reqs;
		host_write(addr_cmd, {cmd_read_multi, 4'h0});
		for (i = 0; i < sector_size; i++) begin
			wait_drq("multi read", ok);
			if (!ok) begin
				break;
			end
			host_read(addr_data, v);
			check_byte($sformatf("multi byte %0d", i), fill_copy[i], v);
		end
		wait_drq("second sector", ok); // second fill done
		host_read(addr_sector, v);
		check_byte("sector advance", 8'h05, v);
		check_byte("read request count", 8'd2, 8'(read_reqs - r0));
		check_req("second request", req_read, wh_req_e'(last_req[7:4]));
		repeat (drq_timeout + 8) @(negedge clk); // host stays away
		host_read(addr_cmd, v);
		check_byte("lost data", bl, v & bl);
		host_write(addr_cmd, {cmd_force_int, 4'h0});
		for (i = 0; i < 20; i++) begin
			host_read(addr_cmd, v);
			if (!v[sbit_busy]) begin
				break;
			end
		end
		if (v[sbit_busy]) begin
			$display("busy still set after force interrupt");
			errors++;
		end
		check_byte("force int status", 8'h00,
			v & (bit_mask(sbit_busy) | bit_mask(sbit_drq_index)));
		check_byte("force int drq", 8'h00, {7'b0, drq});
		report_test("multi read, lost data, force interrupt", e0);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		seed        = 71;
		errors      = 0;
		checks      = 0;
		read_reqs   = 0;
		last_req    = 8'h00;
		fail_answer = 8'h00;
		cock        = 1'b1;
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = addr_cmd;
		idata       = 8'h00;
		repeat (10) @(negedge clk);
		cock = 1'b0;
		@(negedge clk);

		test_registers();
		test_head();
		test_read_single();
		test_write();
		test_failure();
		test_multi_lost();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
fdc_regs_pkg.sv
fdc_host_pkg.sv
fdc_drq_watchdog.sv
fdc_sector_buffer.sv
fdc_host_regs.sv
fdc_ctrl_fsm.sv
fdc_top.sv
fdc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fdc testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module fdc_tb -f list.f -o fdc_sim
./obj_dir/fdc_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
